// File: compile.f
l1_d_pkg.sv
l1_d_skid_buf.sv
l1_d_tag_ctrl.sv
l1_d_data_array.sv
l1_d_resp_merge.sv
l1_d_cache_top.sv
l1_d_l2_model.sv
l1_d_cache_tb.sv

// File: l1_d_cache_tb.sv
module l1_d_cache_tb
    import l1_d_pkg::*;
();

    localparam int max_lines = 64;
    localparam int cols = 5;

    typedef struct packed {
        logic [31:0] rdata;
        logic        write;
        logic [15:0] line;
    } exp_t;

    logic      clk;
    logic      nrst;
    logic      flush;
    logic      req_valid;
    logic      req_ready;
    cpu_req_t  req;
    logic      resp_valid;
    logic      resp_ready;
    cpu_resp_t resp;
    logic      l2_req_valid;
    logic      l2_req_ready;
    l2_req_t   l2_req;
    logic      l2_resp_valid;
    line_t     l2_resp_line;
    int        wb_count;

    // five columns per access: test, op, address, wdata, expected
    logic [31:0] vec [0:max_lines*cols-1];
    int          n_lines;
    exp_t        exp_q [$];
    logic [31:0] lfsr;
    logic        stall_on;
    int          stall_cnt;
    int          cur_test;
    int          test_errs;
    int          err_count;
    int          tests_passed;
    int          tests_failed;

    l1_d_cache_top dut0 (
        .clk           (clk),
        .nrst          (nrst),
        .flush         (flush),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp          (resp),
        .l2_req_valid  (l2_req_valid),
        .l2_req_ready  (l2_req_ready),
        .l2_req        (l2_req),
        .l2_resp_valid (l2_resp_valid),
        .l2_resp_line  (l2_resp_line)
    );

    l1_d_l2_model u_l2 (
        .clk           (clk),
        .nrst          (nrst),
        .l2_req_valid  (l2_req_valid),
        .l2_req_ready  (l2_req_ready),
        .l2_req        (l2_req),
        .l2_resp_valid (l2_resp_valid),
        .l2_resp_line  (l2_resp_line),
        .wb_count      (wb_count)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | {31'd0, lfsr[0]};
        end
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual, input int line);
        if (expected !== actual)
        begin
            $display("Fail %s: expected %08h, actual %08h (entry %0d, test %0d)",
                     name, expected, actual, line, cur_test);
            err_count++;
            test_errs++;
        end
    endtask

    // stalls of one to four cycles while enabled
    task automatic set_resp_ready();
        int b;
        if (!stall_on)
        begin
            resp_ready = 1'b1;
        end
        else if (stall_cnt != 0)
        begin
            stall_cnt--;
            resp_ready = 1'b0;
        end
        else
        begin
            take_bits(1, b);
            if (b != 0)
            begin
                take_bits(2, stall_cnt);
                resp_ready = 1'b0;
            end
            else
            begin
                resp_ready = 1'b1;
            end
        end
    endtask

    // a transfer is decided at the falling edge, it completes at the next rising edge
    task automatic step();
        exp_t e;
        @(negedge clk);
        set_resp_ready();
        if (resp_valid && resp_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("unexpected response %08h with no request outstanding", resp.rdata);
                err_count++;
                test_errs++;
            end
            else
            begin
                e = exp_q.pop_front();
                compare("resp.rdata", e.rdata, resp.rdata, e.line);
                compare("resp.write", {31'd0, e.write}, {31'd0, resp.write}, e.line);
            end
        end
    endtask

    task automatic send(input int k);
        exp_t e;
        req.write = (vec[k*cols+1] == 32'd1);
        req.addr = vec[k*cols+2][27:0];
        req.wdata = vec[k*cols+3];
        req_valid = 1'b1;
        e.rdata = vec[k*cols+4];
        e.write = req.write;
        e.line = k[15:0];
        exp_q.push_back(e);
        while (!req_ready)
        begin
            step();
        end
        step();
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
        begin
            step();
        end
    endtask

    task automatic report_test();
        if (test_errs == 0)
        begin
            $display("test %0d: ok", cur_test);
            tests_passed++;
        end
        else
        begin
            $display("test %0d: %0d mismatches", cur_test, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    initial
    begin
        int i;
        int t;
        int op;
        clk = 1'b0;
        nrst = 1'b0;
        flush = 1'b0;
        req_valid = 1'b0;
        req = '0;
        resp_ready = 1'b0;
        lfsr = 32'd82455;
        stall_on = 1'b0;
        stall_cnt = 0;
        cur_test = 0;
        test_errs = 0;
        err_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (i = 0; i < max_lines * cols; i++)
        begin
            vec[i] = '1;
        end
        $readmemh("l1_d_input.txt", vec);
        n_lines = 0;
        while (n_lines < max_lines && vec[n_lines*cols] != 32'hffffffff)
        begin
            n_lines++;
        end

        repeat (8) @(negedge clk);
        nrst = 1'b1;

        for (i = 0; i < n_lines; i++)
        begin
            t = vec[i*cols];
            if (i != 0 && t != cur_test)
            begin
                drain();
                report_test();
            end
            cur_test = t;
            op = vec[i*cols+1];
            case (op)
                0, 1:
                begin
                    send(i);
                end
                2:
                begin
                    // controller is idle once every response is back
                    drain();
                    flush = 1'b1;
                    step();
                    flush = 1'b0;
                end
                3:
                begin
                    drain();
                    compare("wb_count", vec[i*cols+4], wb_count, i);
                end
                4:
                begin
                    stall_on = vec[i*cols+3][0];
                end
                default:
                begin
                    $display("entry %0d has an unknown op code %0d", i, op);
                    err_count++;
                    test_errs++;
                end
            endcase
        end
        drain();
        report_test();
        // late extra responses still count
        repeat (8) step();

        $display("summary: %0d tests passed, %0d tests failed, %0d mismatches",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial
    begin
        int limit;
        #1;
        limit = n_lines * 40 + 200;
        repeat (limit) @(posedge clk);
        $display("cache hung: run did not finish within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: l1_d_cache_top.sv
module l1_d_cache_top
    import l1_d_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  logic      flush,
    input  logic      req_valid,
    output logic      req_ready,
    input  cpu_req_t  req,
    output logic      resp_valid,
    input  logic      resp_ready,
    output cpu_resp_t resp,
    output logic      l2_req_valid,
    input  logic      l2_req_ready,
    output l2_req_t   l2_req,
    input  logic      l2_resp_valid,
    input  line_t     l2_resp_line
);

    logic                   cc_req_valid;
    logic                   cc_req_ready;
    cpu_req_t               cc_req;
    cpu_req_t               cur_req;
    logic                   l2_req_write;
    logic [line_addr_w-1:0] l2_line_addr;
    logic [tag_w-1:0]       wb_tag;
    logic                   op_valid;
    ctrl_op_t               op;
    line_t                  array_line;
    l2_req_t                wb_req;
    l2_req_t                rd_req;
    logic                   mr_resp_valid;
    logic                   mr_resp_ready;
    cpu_resp_t              mr_resp;
    logic                   resp_done;

    // read requests carry no line
    assign rd_req = '{write: 1'b0, line_addr: l2_line_addr, line: '0};
    assign l2_req = l2_req_write ? wb_req : rd_req;

    l1_d_skid_buf #(
        .payload_t (cpu_req_t)
    ) u_req_buf (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (cc_req_valid),
        .out_ready (cc_req_ready),
        .out_data  (cc_req)
    );

    l1_d_tag_ctrl u_tag_ctrl (
        .clk           (clk),
        .nrst          (nrst),
        .flush         (flush),
        .req_valid     (cc_req_valid),
        .req_ready     (cc_req_ready),
        .req           (cc_req),
        .cur_req       (cur_req),
        .l2_req_valid  (l2_req_valid),
        .l2_req_ready  (l2_req_ready),
        .l2_req_write  (l2_req_write),
        .l2_line_addr  (l2_line_addr),
        .wb_tag        (wb_tag),
        .l2_resp_valid (l2_resp_valid),
        .op_valid      (op_valid),
        .op            (op),
        .resp_done     (resp_done)
    );

    l1_d_data_array u_data_array (
        .clk         (clk),
        .nrst        (nrst),
        .op_valid    (op_valid),
        .op          (op),
        .wdata       (cur_req.wdata),
        .refill_line (l2_resp_line),
        .line_out    (array_line)
    );

    l1_d_resp_merge u_resp_merge (
        .clk         (clk),
        .nrst        (nrst),
        .op_valid    (op_valid),
        .op          (op),
        .line_in     (array_line),
        .refill_line (l2_resp_line),
        .wdata       (cur_req.wdata),
        .req_write   (cur_req.write),
        .wb_tag      (wb_tag),
        .l2_req      (wb_req),
        .resp_valid  (mr_resp_valid),
        .resp_ready  (mr_resp_ready),
        .resp        (mr_resp),
        .resp_done   (resp_done)
    );

    l1_d_skid_buf #(
        .payload_t (cpu_resp_t)
    ) u_resp_buf (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (mr_resp_valid),
        .in_ready  (mr_resp_ready),
        .in_data   (mr_resp),
        .out_valid (resp_valid),
        .out_ready (resp_ready),
        .out_data  (resp)
    );

endmodule

// File: l1_d_data_array.sv
module l1_d_data_array
    import l1_d_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        op_valid,
    input  ctrl_op_t    op,
    input  logic [31:0] wdata,
    input  line_t       refill_line,
    output line_t       line_out
);

    line_t            mem [0:sets*ways-1];
    logic [index_w:0] slot;
    line_t            fill_line;

    assign slot = {op.index, op.way};

    // write miss keeps the other words from L2
    always_comb
    begin
        fill_line = refill_line;
        if (!op.fill_word)
        begin
            fill_line[op.word] = wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (op_valid)
        begin
            if (op.refill)
            begin
                mem[slot] <= fill_line;
                line_out <= fill_line;
            end
            else
            begin
                if (op.wr_hit)
                begin
                    mem[slot][op.word] <= wdata;
                end
                line_out <= mem[slot];
            end
        end
    end

    // one kind of access per op from the controller
    a_op_onehot: assert property (
        @(posedge clk) disable iff (!nrst)
        op_valid |-> $onehot({op.rd_hit, op.wr_hit, op.refill, op.wb_read})
    );

endmodule

// File: l1_d_input.txt
// columns: test  op  word address  write data  expected response data
// op 0 read, 1 write, 2 flush, 3 check L2 write-back count, 4 resp_ready stalls (wdata 1 on)
1 0 0000010 00000000 a0000010
1 0 0000010 00000000 a0000010
1 0 0000013 00000000 a0000013
2 1 0000011 11112222 11112222
2 0 0000011 00000000 11112222
2 1 0000020 33334444 33334444
2 0 0000021 00000000 a0000021
2 0 0000020 00000000 33334444
3 1 0000084 aaaa0001 aaaa0001
3 1 0000105 bbbb0001 bbbb0001
3 0 0000084 00000000 aaaa0001
3 0 0000186 00000000 a0000186
3 3 0000000 00000000 00000001
3 0 0000087 00000000 a0000087
3 0 0000105 00000000 bbbb0001
4 1 0000030 55556666 55556666
4 0 0000030 00000000 55556666
4 2 0000000 00000000 00000000
4 0 0000030 00000000 a0000030
4 0 0000084 00000000 a0000084
4 0 0000105 00000000 bbbb0001
4 3 0000000 00000000 00000001
5 4 0000000 00000001 00000000
5 1 0000200 77770000 77770000
5 0 0000201 00000000 a0000201
5 0 0000200 00000000 77770000
5 1 0000303 88880003 88880003
5 0 0000300 00000000 a0000300
5 0 0000303 00000000 88880003
5 0 0000031 00000000 a0000031
5 0 0000106 00000000 a0000106
5 0 0000380 00000000 a0000380
5 0 0000202 00000000 a0000202
5 0 0000200 00000000 77770000
5 0 0000303 00000000 88880003
5 3 0000000 00000000 00000003

// File: l1_d_l2_model.sv
module l1_d_l2_model
    import l1_d_pkg::*;
(
    input  logic    clk,
    input  logic    nrst,
    input  logic    l2_req_valid,
    output logic    l2_req_ready,
    input  l2_req_t l2_req,
    output logic    l2_resp_valid,
    output line_t   l2_resp_line,
    output int      wb_count
);

    // only written-back words are stored, the rest follow the fill pattern
    logic [31:0] mem [logic [27:0]];
    logic [31:0] lfsr;
    l2_req_t     req_q;
    int          delay;
    int          w;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | {31'd0, lfsr[0]};
        end
    endtask

    function automatic logic [31:0] read_word(input logic [27:0] a);
        if (mem.exists(a))
        begin
            return mem[a];
        end
        return {4'hA, a};
    endfunction

    initial
    begin
        l2_req_ready = 1'b0;
        l2_resp_valid = 1'b0;
        l2_resp_line = '0;
        wb_count = 0;
        lfsr = 32'd82455;
        forever
        begin
            @(negedge clk);
            if (nrst && l2_req_valid)
            begin
                take_bits(2, delay);
                repeat (delay) @(negedge clk);
                req_q = l2_req;
                l2_req_ready = 1'b1;
                @(negedge clk);
                l2_req_ready = 1'b0;
                if (req_q.write)
                begin
                    for (w = 0; w < words_per_line; w++)
                    begin
                        mem[{req_q.line_addr, w[1:0]}] = req_q.line[w[1:0]];
                    end
                    wb_count++;
                end
                else
                begin
                    // refill reply after its own random delay
                    take_bits(2, delay);
                    repeat (delay) @(negedge clk);
                    for (w = 0; w < words_per_line; w++)
                    begin
                        l2_resp_line[w[1:0]] = read_word({req_q.line_addr, w[1:0]});
                    end
                    l2_resp_valid = 1'b1;
                    @(negedge clk);
                    l2_resp_valid = 1'b0;
                end
            end
        end
    end

endmodule

// File: l1_d_pkg.sv
package l1_d_pkg;

    // address fields of a 28-bit word address
    localparam int tag_w = 21;
    localparam int index_w = 5;
    localparam int word_w = 2;
    localparam int line_addr_w = tag_w + index_w;

    // geometry
    localparam int ways = 2;
    localparam int sets = 32;
    localparam int words_per_line = 4;

    typedef struct packed {
        logic [tag_w-1:0]   tag;
        logic [index_w-1:0] index;
        logic [word_w-1:0]  word;
    } addr_t;

    typedef logic [words_per_line-1:0][31:0] line_t;

    typedef struct packed {
        logic        write;
        addr_t       addr;
        logic [31:0] wdata;
    } cpu_req_t;

    // write flag is echoed back to the core
    typedef struct packed {
        logic [31:0] rdata;
        logic        write;
    } cpu_resp_t;

    typedef struct packed {
        logic                   write;
        logic [line_addr_w-1:0] line_addr;
        line_t                  line;
    } l2_req_t;

    // fill_word set: answered word comes from the refill line
    typedef struct packed {
        logic [index_w-1:0] index;
        logic               way;
        logic [word_w-1:0]  word;
        logic               rd_hit;
        logic               wr_hit;
        logic               refill;
        logic               wb_read;
        logic               fill_word;
    } ctrl_op_t;

endpackage

// File: l1_d_resp_merge.sv
module l1_d_resp_merge
    import l1_d_pkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    input  logic             op_valid,
    input  ctrl_op_t         op,
    input  line_t            line_in,
    input  line_t            refill_line,
    input  logic [31:0]      wdata,
    input  logic             req_write,
    input  logic [tag_w-1:0] wb_tag,
    output l2_req_t          l2_req,
    output logic             resp_valid,
    input  logic             resp_ready,
    output cpu_resp_t        resp,
    output logic             resp_done
);

    ctrl_op_t    op_q;
    logic        op_valid_q;
    logic [31:0] fill_q;
    logic        answer;

    // array line lands one cycle after the op
    assign answer = op_valid_q && (op_q.rd_hit || op_q.wr_hit || op_q.refill);
    assign resp_done = resp_valid && resp_ready;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            op_valid_q <= 1'b0;
            resp_valid <= 1'b0;
        end
        else
        begin
            op_valid_q <= op_valid;
            if (answer)
            begin
                resp_valid <= 1'b1;
            end
            else if (resp_done)
            begin
                resp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (op_valid)
        begin
            op_q <= op;
            // refill line is only present this cycle
            if (op.fill_word)
            begin
                fill_q <= refill_line[op.word];
            end
        end
        if (answer)
        begin
            resp.write <= req_write;
            if (req_write)
            begin
                resp.rdata <= wdata;
            end
            else
            begin
                resp.rdata <= op_q.fill_word ? fill_q : line_in[op_q.word];
            end
        end
        if (op_valid_q && op_q.wb_read)
        begin
            l2_req.write <= 1'b1;
            l2_req.line_addr <= {wb_tag, op_q.index};
            l2_req.line <= line_in;
        end
    end

endmodule

// File: l1_d_skid_buf.sv
module l1_d_skid_buf #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // free when empty, or when the held item leaves this cycle
    assign in_ready = !full || out_ready;
    assign out_valid = full;
    assign out_data = data_q;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            full <= 1'b0;
        end
        else if (in_ready)
        begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            data_q <= in_data;
        end
    end

    // stalled output keeps its payload
    a_out_stable: assert property (
        @(posedge clk) disable iff (!nrst)
        out_valid && !out_ready |=> $stable(out_data)
    );

endmodule

// File: l1_d_tag_ctrl.sv
module l1_d_tag_ctrl
    import l1_d_pkg::*;
(
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   flush,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  cpu_req_t               req,
    output cpu_req_t               cur_req,
    output logic                   l2_req_valid,
    input  logic                   l2_req_ready,
    output logic                   l2_req_write,
    output logic [line_addr_w-1:0] l2_line_addr,
    output logic [tag_w-1:0]       wb_tag,
    input  logic                   l2_resp_valid,
    output logic                   op_valid,
    output ctrl_op_t               op,
    input  logic                   resp_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_COMPARE,
        S_WRITE_BACK,
        S_ALLOCATE,
        S_REFILL,
        S_RESPOND
    } state_t;

    state_t state;

    logic [tag_w-1:0]     tag_arr [0:sets*ways-1];
    logic [sets*ways-1:0] valid;
    logic [sets*ways-1:0] dirty;
    // lru bit names the way to replace next
    logic [sets-1:0]      lru;

    ctrl_op_t           op_q;
    ctrl_op_t           cmp_op;
    logic               op_pulse;
    logic [1:0]         wb_wait;
    logic [tag_w-1:0]   wb_tag_q;

    logic [index_w-1:0] idx;
    logic               hit0;
    logic               hit1;
    logic               hit;
    logic               hit_way;
    logic               victim;
    logic               victim_dirty;
    logic [index_w:0]   hit_slot;
    logic [index_w:0]   vic_slot;

    assign idx = cur_req.addr.index;
    assign hit0 = valid[{idx, 1'b0}] && (tag_arr[{idx, 1'b0}] == cur_req.addr.tag);
    assign hit1 = valid[{idx, 1'b1}] && (tag_arr[{idx, 1'b1}] == cur_req.addr.tag);
    assign hit = hit0 || hit1;
    assign hit_way = !hit0;

    // free way first, way 0 before way 1, then lru
    assign victim = !valid[{idx, 1'b0}] ? 1'b0 :
                    !valid[{idx, 1'b1}] ? 1'b1 : lru[idx];
    assign hit_slot = {idx, hit_way};
    assign vic_slot = {idx, victim};
    assign victim_dirty = valid[vic_slot] && dirty[vic_slot];

    always_comb
    begin
        cmp_op = '0;
        cmp_op.index = idx;
        cmp_op.word = cur_req.addr.word;
        cmp_op.way = hit ? hit_way : victim;
        cmp_op.rd_hit = hit && !cur_req.write;
        cmp_op.wr_hit = hit && cur_req.write;
        cmp_op.wb_read = !hit && victim_dirty;
    end

    assign req_ready = (state == S_IDLE);
    assign l2_req_valid = ((state == S_WRITE_BACK) && (wb_wait == 2'd0))
                          || (state == S_ALLOCATE);
    assign l2_req_write = (state == S_WRITE_BACK);
    assign l2_line_addr = {cur_req.addr.tag, idx};
    assign wb_tag = wb_tag_q;

    // refill op goes out in the cycle the line arrives
    assign op = op_q;
    assign op_valid = op_pulse || ((state == S_REFILL) && l2_resp_valid);

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state <= S_IDLE;
            valid <= '0;
            dirty <= '0;
            lru <= '0;
            op_pulse <= 1'b0;
            wb_wait <= 2'd0;
        end
        else
        begin
            op_pulse <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (flush)
                    begin
                        valid <= '0;
                        dirty <= '0;
                    end
                    if (req_valid)
                    begin
                        state <= S_COMPARE;
                    end
                end
                S_COMPARE:
                begin
                    if (hit)
                    begin
                        op_pulse <= 1'b1;
                        lru[idx] <= !hit_way;
                        if (cur_req.write)
                        begin
                            dirty[hit_slot] <= 1'b1;
                        end
                        state <= S_RESPOND;
                    end
                    else if (victim_dirty)
                    begin
                        // array read, then combiner capture
                        op_pulse <= 1'b1;
                        wb_wait <= 2'd2;
                        state <= S_WRITE_BACK;
                    end
                    else
                    begin
                        state <= S_ALLOCATE;
                    end
                end
                S_WRITE_BACK:
                begin
                    if (wb_wait != 2'd0)
                    begin
                        wb_wait <= wb_wait - 2'd1;
                    end
                    else if (l2_req_ready)
                    begin
                        state <= S_ALLOCATE;
                    end
                end
                S_ALLOCATE:
                begin
                    if (l2_req_ready)
                    begin
                        state <= S_REFILL;
                    end
                end
                S_REFILL:
                begin
                    if (l2_resp_valid)
                    begin
                        valid[{idx, op_q.way}] <= 1'b1;
                        dirty[{idx, op_q.way}] <= cur_req.write;
                        lru[idx] <= !op_q.way;
                        state <= S_RESPOND;
                    end
                end
                S_RESPOND:
                begin
                    if (resp_done)
                    begin
                        state <= S_IDLE;
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == S_IDLE) && req_valid)
        begin
            cur_req <= req;
        end
        if (state == S_COMPARE)
        begin
            op_q <= cmp_op;
            wb_tag_q <= tag_arr[vic_slot];
        end
        if ((state == S_ALLOCATE) && l2_req_ready)
        begin
            op_q.rd_hit <= 1'b0;
            op_q.wr_hit <= 1'b0;
            op_q.wb_read <= 1'b0;
            op_q.refill <= 1'b1;
            op_q.fill_word <= !cur_req.write;
        end
        if ((state == S_REFILL) && l2_resp_valid)
        begin
            tag_arr[{idx, op_q.way}] <= cur_req.addr.tag;
        end
    end

    a_l2_req_hold: assert property (
        @(posedge clk) disable iff (!nrst)
        l2_req_valid && !l2_req_ready |=>
            l2_req_valid && $stable(l2_req_write) && $stable(l2_line_addr)
    );

    a_refill_expected: assert property (
        @(posedge clk) disable iff (!nrst)
        l2_resp_valid |-> state == S_REFILL
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the L1 data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module l1_d_cache_tb \
    -f compile.f -Mdir obj_dir -o sim_l1_d
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_l1_d)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
exit 1
